//--- len5_config.svh
`ifndef LEN5_CONFIG_SVH
`define LEN5_CONFIG_SVH

// ------------------------------
// core configuration
// ------------------------------

// data and address width
`define LEN5_XLEN 32

`define LEN5_BOOT_PC 32'h0000_0000 // first fetch address
`define LEN5_TRAP_PC 32'h0000_0100 // where every exception lands

// btb index width, 8 entries
`define LEN5_BTB_BITS 3

`endif

//--- len5_pkg.sv
`include "len5_config.svh"

package len5_pkg;

  // ------------------------------
  // basic types
  // ------------------------------
  typedef logic [`LEN5_XLEN-1:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [3:0] except_code_t;

  localparam except_code_t EXC_INSTR_FAULT = 4'd1; // instruction access fault
  localparam except_code_t EXC_ILLEGAL     = 4'd2; // unsupported opcode

  typedef enum logic {
    FS_REQ,  // request goes out this cycle
    FS_WAIT  // waiting for the memory answer
  } fetch_state_t;

  // ------------------------------
  // stage to stage bundles
  // ------------------------------
  typedef struct packed {
    logic  taken;
    xlen_t target; // pc+4 when not taken
  } prediction_t;

  typedef struct packed {
    xlen_t        pc;
    instr_t       instr;
    prediction_t  pred;
    logic         except_raised;
    except_code_t except_code;
  } issue_t;

  typedef struct packed {
    xlen_t pc;
    xlen_t target;     // actual next pc
    logic  is_branch;  // trains the btb
    logic  taken;
    logic  mispredict;
  } resolution_t;

  typedef struct packed {
    xlen_t        pc;
    reg_idx_t     rd;
    xlen_t        value;
    logic         except_raised;
    except_code_t except_code;
  } commit_t;

endpackage

//--- branch_predictor.sv
`timescale 1ns/1ps
`include "len5_config.svh"

module branch_predictor #(
  parameter int BTB_BITS = `LEN5_BTB_BITS
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  len5_pkg::xlen_t       lookup_pc_i,
  output len5_pkg::prediction_t pred_o,
  input  logic                  res_valid_i,
  input  len5_pkg::resolution_t res_i
);

  import len5_pkg::*;

  localparam int ENTRIES = 1 << BTB_BITS;
  localparam int TAG_LSB = BTB_BITS + 2; // word aligned pcs

  typedef logic [BTB_BITS-1:0] btb_idx_t;
  typedef logic [`LEN5_XLEN-1:TAG_LSB] btb_tag_t;
  typedef logic [1:0] sat_cnt_t;

  logic [ENTRIES-1:0] valid_q;
  btb_tag_t           tag_q [ENTRIES];
  xlen_t              target_q [ENTRIES];
  sat_cnt_t           cnt_q [ENTRIES];

  btb_idx_t lookup_idx;
  btb_idx_t upd_idx;
  logic     lookup_hit;
  logic     upd_hit;
  sat_cnt_t cnt_base;
  sat_cnt_t cnt_next;

  // ------------------------------
  // lookup
  // ------------------------------
  assign lookup_idx = lookup_pc_i[TAG_LSB-1:2];
  assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_pc_i[`LEN5_XLEN-1:TAG_LSB]);

  always_comb begin
    pred_o.taken  = lookup_hit && cnt_q[lookup_idx][1]; // 2 or 3 predicts taken
    pred_o.target = pred_o.taken ? target_q[lookup_idx] : lookup_pc_i + 32'd4;
  end

  // ------------------------------
  // training
  // ------------------------------
  assign upd_idx  = res_i.pc[TAG_LSB-1:2];
  assign upd_hit  = valid_q[upd_idx] && (tag_q[upd_idx] == res_i.pc[`LEN5_XLEN-1:TAG_LSB]);
  assign cnt_base = upd_hit ? cnt_q[upd_idx] : 2'b01; // fresh entry, weakly not taken

  always_comb begin
    if (res_i.taken) begin
      cnt_next = (cnt_base == 2'b11) ? cnt_base : cnt_base + 2'd1;
    end else begin
      cnt_next = (cnt_base == 2'b00) ? cnt_base : cnt_base - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (res_valid_i && res_i.is_branch) begin
      valid_q[upd_idx] <= 1'b1;
      cnt_q[upd_idx]   <= cnt_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_i.is_branch) begin
      tag_q[upd_idx]    <= res_i.pc[`LEN5_XLEN-1:TAG_LSB];
      target_q[upd_idx] <= res_i.target;
    end
  end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "len5_config.svh"

module fetch_stage #(
  parameter int BTB_BITS = `LEN5_BTB_BITS
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // instruction memory
  output logic                   instr_req_o,
  output len5_pkg::xlen_t        instr_addr_o,
  output logic                   instr_tag_o,
  input  logic                   instr_rvalid_i,
  input  len5_pkg::instr_t       instr_rdata_i,
  input  logic                   instr_tag_i,
  input  logic                   instr_except_raised_i,
  input  len5_pkg::except_code_t instr_except_code_i,
  // resolution from the backend
  input  logic                   res_valid_i,
  input  len5_pkg::resolution_t  res_i,
  // issue to the backend
  output logic                   issue_valid_o,
  output len5_pkg::issue_t       issue_o
);

  import len5_pkg::*;

  fetch_state_t state_q;
  xlen_t        pc_q;     // address of the current request
  logic         epoch_q;
  prediction_t  pred_q;   // prediction for pc_q, rides along to issue
  prediction_t  bp_pred;
  logic         flush;
  logic         rsp_ok;

  branch_predictor #(
    .BTB_BITS(BTB_BITS)
  ) u_branch_predictor (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .lookup_pc_i(pc_q),
    .pred_o     (bp_pred),
    .res_valid_i(res_valid_i),
    .res_i      (res_i)
  );

  assign flush  = res_valid_i && res_i.mispredict;
  assign rsp_ok = (state_q == FS_WAIT) && instr_rvalid_i && (instr_tag_i == epoch_q);

  // ------------------------------
  // memory request
  // ------------------------------
  assign instr_req_o  = (state_q == FS_REQ) && !rst_i; // boot request right after reset
  assign instr_addr_o = pc_q;
  assign instr_tag_o  = epoch_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FS_REQ;
      pc_q    <= `LEN5_BOOT_PC;
      epoch_q <= 1'b0;
    end else begin
      case (state_q)
        FS_REQ: state_q <= FS_WAIT;
        FS_WAIT: begin
          if (instr_rvalid_i) begin
            state_q <= FS_REQ; // stale answers also free the slot
          end
          if (rsp_ok) begin
            pc_q <= pred_q.target;
          end
        end
        default: state_q <= FS_REQ;
      endcase
      // redirect wins over the predicted pc
      if (flush) begin
        pc_q    <= res_i.target;
        epoch_q <= ~epoch_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FS_REQ) begin
      pred_q <= bp_pred;
    end
  end

  // ------------------------------
  // issue
  // ------------------------------
  assign issue_valid_o = rsp_ok && !flush;

  always_comb begin
    issue_o.pc            = pc_q;
    issue_o.instr         = instr_rdata_i;
    issue_o.pred          = pred_q;
    issue_o.except_raised = instr_except_raised_i;
    issue_o.except_code   = instr_except_code_i;
  end

endmodule

//--- backend.sv
`timescale 1ns/1ps
`include "len5_config.svh"

module backend (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  issue_valid_i,
  input  len5_pkg::issue_t      issue_i,
  output logic                  res_valid_o,
  output len5_pkg::resolution_t res_o,
  output logic                  commit_valid_o,
  output len5_pkg::commit_t     commit_o
);

  import len5_pkg::*;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  instr_t       instr;
  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  reg_idx_t     rd;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  xlen_t        imm_i;
  xlen_t        imm_u;
  xlen_t        imm_b;
  xlen_t        imm_j;
  xlen_t        regfile_q [32];
  xlen_t        rs1_val;
  xlen_t        rs2_val;
  xlen_t        result;
  xlen_t        link_pc;
  xlen_t        jump_pc;
  xlen_t        next_pc;
  logic         legal;
  logic         wr_en;
  logic         taken;
  logic         is_branch;
  logic         except_raised;
  except_code_t except_code;

  // ------------------------------
  // decode and operand read
  // ------------------------------
  assign instr  = issue_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs1_val = (rs1 == '0) ? '0 : regfile_q[rs1]; // x0 hardwired
  assign rs2_val = (rs2 == '0) ? '0 : regfile_q[rs2];
  assign link_pc = issue_i.pc + 32'd4;
  assign jump_pc = issue_i.pc + ((opcode == OPC_JAL) ? imm_j : imm_b);

  // ------------------------------
  // execute and resolve
  // ------------------------------
  always_comb begin
    legal     = 1'b1;
    wr_en     = 1'b0;
    taken     = 1'b0;
    is_branch = 1'b0;
    result    = '0;
    case (opcode)
      OPC_OP_IMM: begin
        legal  = (funct3 == 3'b000); // addi only
        wr_en  = legal;
        result = rs1_val + imm_i;
      end
      OPC_OP: begin
        legal  = (funct3 == 3'b000) && ((funct7 == '0) || (funct7 == F7_SUB));
        wr_en  = legal;
        result = (funct7 == F7_SUB) ? rs1_val - rs2_val : rs1_val + rs2_val;
      end
      OPC_LUI: begin
        wr_en  = 1'b1;
        result = imm_u;
      end
      OPC_BRANCH: begin
        legal     = (funct3 == 3'b000) || (funct3 == 3'b001); // beq, bne
        is_branch = legal;
        taken     = legal && ((rs1_val == rs2_val) ^ funct3[0]);
      end
      OPC_JAL: begin
        wr_en     = 1'b1;
        result    = link_pc;
        taken     = 1'b1;
        is_branch = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // a faulted fetch carries no usable instruction word
    except_raised = issue_i.except_raised || !legal;
    except_code   = issue_i.except_raised ? issue_i.except_code : EXC_ILLEGAL;
    if (except_raised) begin
      wr_en     = 1'b0;
      taken     = 1'b0;
      is_branch = 1'b0;
      next_pc   = `LEN5_TRAP_PC;
    end else begin
      next_pc = taken ? jump_pc : link_pc;
    end
  end

  // ------------------------------
  // commit and resolution
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_o    <= 1'b0;
      commit_valid_o <= 1'b0;
    end else begin
      res_valid_o    <= issue_valid_i;
      commit_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      res_o.pc               <= issue_i.pc;
      res_o.target           <= next_pc;
      res_o.is_branch        <= is_branch;
      res_o.taken            <= taken;
      res_o.mispredict       <= except_raised || (next_pc != issue_i.pred.target);
      commit_o.pc            <= issue_i.pc;
      commit_o.rd            <= wr_en ? rd : '0; // rd 0 means no write
      commit_o.value         <= wr_en ? result : '0;
      commit_o.except_raised <= except_raised;
      commit_o.except_code   <= except_raised ? except_code : '0;
    end
  end

  // writeback happens when the commit is visible
  always_ff @(posedge clk_i) begin
    if (commit_valid_o && (commit_o.rd != '0)) begin
      regfile_q[commit_o.rd] <= commit_o.value;
    end
  end

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "len5_config.svh"

module datapath (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // instruction memory
  output logic                   instr_req_o,
  output len5_pkg::xlen_t        instr_addr_o,
  output logic                   instr_tag_o,
  input  logic                   instr_rvalid_i,
  input  len5_pkg::instr_t       instr_rdata_i,
  input  logic                   instr_tag_i,
  input  logic                   instr_except_raised_i,
  input  len5_pkg::except_code_t instr_except_code_i,
  // retirement trace
  output logic                   commit_valid_o,
  output len5_pkg::commit_t      commit_o,
  output logic                   mem_flush_o
);

  import len5_pkg::*;

  // ------------------------------
  // front end to back end
  // ------------------------------
  logic        issue_valid;
  issue_t      issue;
  logic        res_valid;
  resolution_t res;
  logic        mis_flush;

  fetch_stage #(
    .BTB_BITS(`LEN5_BTB_BITS)
  ) u_fetch_stage (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .instr_req_o          (instr_req_o),
    .instr_addr_o         (instr_addr_o),
    .instr_tag_o          (instr_tag_o),
    .instr_rvalid_i       (instr_rvalid_i),
    .instr_rdata_i        (instr_rdata_i),
    .instr_tag_i          (instr_tag_i),
    .instr_except_raised_i(instr_except_raised_i),
    .instr_except_code_i  (instr_except_code_i),
    .res_valid_i          (res_valid),
    .res_i                (res),
    .issue_valid_o        (issue_valid),
    .issue_o              (issue)
  );

  backend u_backend (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .res_valid_o   (res_valid),
    .res_o         (res),
    .commit_valid_o(commit_valid_o),
    .commit_o      (commit_o)
  );

  assign mis_flush   = res_valid && res.mispredict; // redirect, also drops memory state
  assign mem_flush_o = mis_flush;

endmodule

//--- datapath_properties.sv
`timescale 1ns/1ps

module datapath_properties (
  input logic clk_i,
  input logic rst_i,
  input logic instr_req_i,
  input logic instr_rvalid_i,
  input logic commit_valid_i,
  input logic mem_flush_i,
  input logic issue_valid_i,
  input logic res_valid_i
);

  int unsigned fail_count = 0; // failed assertions so far
  logic        outstanding_q;

  // one request in flight until its answer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // ------------------------------
  // memory and flush protocol
  // ------------------------------
  a_single_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_i |-> !outstanding_q)
    else begin fail_count++; $error("request issued while one is outstanding"); end

  a_flush_with_commit: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_flush_i |-> commit_valid_i)
    else begin fail_count++; $error("flush without a commit"); end

  a_commit_after_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_valid_i |-> $past(instr_rvalid_i))
    else begin fail_count++; $error("commit without a preceding response"); end

  // first reset edge may still show old values
  a_quiet_in_reset: assert property (@(posedge clk_i)
    (rst_i && $past(rst_i)) |->
      !(instr_req_i || commit_valid_i || mem_flush_i || issue_valid_i || res_valid_i))
    else begin fail_count++; $error("control output active during reset"); end

endmodule

bind datapath datapath_properties u_datapath_properties (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .instr_req_i   (instr_req_o),
  .instr_rvalid_i(instr_rvalid_i),
  .commit_valid_i(commit_valid_o),
  .mem_flush_i   (mem_flush_o),
  .issue_valid_i (issue_valid),
  .res_valid_i   (res_valid)
);

//--- tb_datapath.sv
`timescale 1ns/1ps
`include "len5_config.svh"

module tb_datapath;

  import len5_pkg::*;

  localparam int TOTAL_COMMITS   = 45;
  localparam int WATCHDOG_CYCLES = TOTAL_COMMITS * 4 * 3 + 6 * 12 + 200;

  logic         clk_i;
  logic         rst_i;
  logic         instr_req_o;
  xlen_t        instr_addr_o;
  logic         instr_tag_o;
  logic         instr_rvalid_i;
  instr_t       instr_rdata_i;
  logic         instr_tag_i;
  logic         instr_except_raised_i;
  except_code_t instr_except_code_i;
  logic         commit_valid_o;
  commit_t      commit_o;
  logic         mem_flush_o;

  instr_t       imem [128];
  xlen_t        fault_addrs [$];
  xlen_t        gregs [32];   // golden register file
  int           bht [xlen_t]; // golden 2-bit counters per branch pc
  xlen_t        gpc;
  logic [15:0]  lfsr_q;
  logic         in_reset;
  logic         req_seen;
  xlen_t        req_addr;
  logic         req_tag;
  logic         pending;
  int           wait_cnt;
  xlen_t        rsp_addr;
  logic         rsp_tag;
  int           errors;
  int           tests;
  int           branch_flushes;

  datapath u_datapath (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
  endtask

  function automatic instr_t enc_addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic instr_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic instr_t enc_lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic instr_t enc_branch(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic instr_t enc_jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic is_fault(xlen_t addr);
    foreach (fault_addrs[i]) begin
      if (fault_addrs[i] == addr) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic clear_program();
    for (int i = 0; i < 128; i++) begin
      imem[i] = {i[24:0], 7'b0000000}; // opcode 0 never decodes
    end
    fault_addrs.delete();
  endtask

  task automatic check_hex(string sig, logic [31:0] exp, logic [31:0] got);
    assert (got === exp)
    else begin
      $display("error %s expected %h got %h", sig, exp, got);
      errors++;
    end
  endtask

  // ------------------------------
  // instruction memory model
  // ------------------------------
  always @(negedge clk_i) begin
    in_reset = rst_i;
    req_seen = !rst_i && instr_req_o;
    if (req_seen) begin
      req_addr = instr_addr_o;
      req_tag  = instr_tag_o;
    end
  end

  always @(posedge clk_i) begin
    logic b0;
    logic b1;
    #1;
    instr_rvalid_i        = 1'b0;
    instr_except_raised_i = 1'b0;
    instr_except_code_i   = '0;
    instr_rdata_i         = '0;
    if (in_reset) begin
      pending = 1'b0;
    end else begin
      if (req_seen) begin
        take_bit(b0);
        take_bit(b1);
        wait_cnt = 1 + 32'({b1, b0}); // 1 to 4 cycles
        pending  = 1'b1;
        rsp_addr = req_addr;
        rsp_tag  = req_tag;
      end
      if (pending && wait_cnt == 1) begin
        instr_rvalid_i = 1'b1;
        instr_tag_i    = rsp_tag;
        pending        = 1'b0;
        if (is_fault(rsp_addr)) begin
          instr_except_raised_i = 1'b1;
          instr_except_code_i   = EXC_INSTR_FAULT;
        end else begin
          instr_rdata_i = imem[rsp_addr[8:2]];
        end
      end else if (pending) begin
        wait_cnt--;
      end
    end
  end

  // ------------------------------
  // golden model and checks
  // ------------------------------
  task automatic check_commit();
    instr_t       ins;
    xlen_t        a;
    xlen_t        b;
    xlen_t        next;
    xlen_t        val;
    reg_idx_t     rd;
    logic         exc;
    except_code_t code;
    logic         cond;
    logic         taken;
    logic         pred_taken;
    exc   = 1'b0;
    code  = '0;
    cond  = 1'b0;
    taken = 1'b0;
    rd    = '0;
    val   = '0;
    next  = gpc + 32'd4;
    ins   = imem[gpc[8:2]];
    a     = gregs[ins[19:15]];
    b     = gregs[ins[24:20]];
    if (is_fault(gpc)) begin
      exc  = 1'b1;
      code = EXC_INSTR_FAULT;
    end else if (ins[6:0] == 7'b0010011 && ins[14:12] == 3'b000) begin
      rd  = ins[11:7];
      val = a + {{20{ins[31]}}, ins[31:20]};
    end else if (ins[6:0] == 7'b0110011 && ins[14:12] == 3'b000 &&
                 (ins[31:25] == 7'h00 || ins[31:25] == 7'h20)) begin
      rd  = ins[11:7];
      val = ins[30] ? a - b : a + b;
    end else if (ins[6:0] == 7'b0110111) begin
      rd  = ins[11:7];
      val = {ins[31:12], 12'b0};
    end else if (ins[6:0] == 7'b1100011 && ins[14:13] == 2'b00) begin
      cond  = 1'b1;
      taken = (a == b) ^ ins[12];
      if (taken) begin
        next = gpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
    end else if (ins[6:0] == 7'b1101111) begin
      rd   = ins[11:7];
      val  = gpc + 32'd4;
      next = gpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    end else begin
      exc  = 1'b1;
      code = EXC_ILLEGAL;
    end
    if (exc) begin
      rd   = '0;
      val  = '0;
      next = `LEN5_TRAP_PC;
    end
    check_hex("commit_o.pc", gpc, commit_o.pc);
    check_hex("commit_o.rd", 32'(rd), 32'(commit_o.rd));
    check_hex("commit_o.value", val, commit_o.value);
    check_hex("commit_o.except_raised", 32'(exc), 32'(commit_o.except_raised));
    check_hex("commit_o.except_code", 32'(code), 32'(commit_o.except_code));
    if (exc) check_hex("mem_flush_o", 1, 32'(mem_flush_o));
    if (cond) begin
      pred_taken = bht.exists(gpc) && bht[gpc] >= 2;
      check_hex("mem_flush_o", 32'(pred_taken != taken), 32'(mem_flush_o));
      if (!bht.exists(gpc)) bht[gpc] = 1; // new entries weakly not taken
      if (taken && bht[gpc] < 3) bht[gpc]++;
      if (!taken && bht[gpc] > 0) bht[gpc]--;
      if (mem_flush_o) branch_flushes++;
    end
    if (rd != 0) gregs[rd] = val;
    gpc = next;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #1 rst_i = 1'b1;
    @(posedge clk_i);
    repeat (9) begin
      @(negedge clk_i);
      assert (!instr_req_o && !commit_valid_o && !mem_flush_o)
      else begin
        $display("control output active while reset is held");
        errors++;
      end
      @(posedge clk_i);
    end
    #1 rst_i = 1'b0;
    @(negedge clk_i);
    check_hex("instr_req_o", 1, 32'(instr_req_o)); // boot request right away
    check_hex("instr_addr_o", `LEN5_BOOT_PC, instr_addr_o);
    check_hex("instr_tag_o", 0, 32'(instr_tag_o));
  endtask

  task automatic run_test(string name, int n, int exp_flushes);
    int commits;
    int err_start;
    commits        = 0;
    err_start      = errors;
    branch_flushes = 0;
    gpc            = `LEN5_BOOT_PC;
    bht.delete();
    apply_reset();
    while (commits < n) begin
      @(negedge clk_i);
      if (commit_valid_o) begin
        check_commit();
        commits++;
      end
    end
    if (exp_flushes >= 0) check_hex("branch flush count", exp_flushes, branch_flushes);
    tests++;
    $display("test %s: %0d commits, %0d errors", name, commits, errors - err_start);
  endtask

  // ------------------------------
  // programs
  // ------------------------------
  initial begin
    rst_i                 = 1'b1;
    instr_rvalid_i        = 1'b0;
    instr_rdata_i         = '0;
    instr_tag_i           = 1'b0;
    instr_except_raised_i = 1'b0;
    instr_except_code_i   = '0;
    lfsr_q                = 16'd55269;
    in_reset              = 1'b1;
    req_seen              = 1'b0;
    pending               = 1'b0;
    errors                = 0;
    tests                 = 0;
    foreach (gregs[i]) gregs[i] = '0;

    clear_program();
    imem[0] = enc_addi(1, 0, 1);
    imem[1] = enc_jal(0, 0);
    run_test("reset_boot", 3, -1);

    clear_program();
    imem[0] = enc_addi(1, 0, 12'h123);
    imem[1] = enc_lui(2, 20'h12345);
    imem[2] = enc_r(0, 0, 3, 1, 2);      // add
    imem[3] = enc_r(7'h20, 0, 4, 3, 1);  // sub
    imem[4] = enc_addi(0, 1, 7);         // x0 stays zero
    imem[5] = enc_r(0, 0, 5, 0, 1);
    imem[6] = enc_r(7'h20, 0, 6, 0, 1);
    imem[7] = enc_addi(7, 6, -2048);
    imem[8] = enc_jal(0, 0);
    run_test("alu_sequence", 10, -1);

    clear_program();
    imem[0] = enc_addi(1, 0, 5);
    imem[1] = enc_addi(1, 1, -1);
    imem[2] = enc_branch(3'b001, 1, 0, -4); // bne back to 0x04
    imem[3] = enc_jal(0, 0);
    run_test("branch_loop", 13, 2);

    clear_program();
    imem[0] = enc_addi(1, 0, 1);
    imem[1] = enc_jal(2, 12);
    imem[2] = enc_addi(3, 0, 99);          // wrong path
    imem[3] = enc_addi(3, 0, 98);
    imem[4] = enc_branch(3'b000, 1, 1, 8); // beq taken
    imem[5] = enc_addi(4, 0, 77);          // wrong path
    imem[6] = enc_addi(5, 2, 3);
    imem[7] = enc_branch(3'b000, 1, 0, 8); // beq not taken
    imem[8] = enc_jal(0, 0);
    run_test("stale_responses", 8, -1);

    clear_program();
    imem[0]  = enc_addi(1, 0, 11);
    imem[1]  = enc_addi(2, 0, 22);
    imem[2]  = enc_addi(2, 0, 33); // fetch faults, must not write
    imem[64] = enc_addi(3, 2, 0);
    imem[65] = enc_jal(0, 0);
    fault_addrs.push_back(32'h0000_0008);
    run_test("access_fault", 6, -1);

    clear_program();
    imem[0]  = enc_addi(1, 0, 5);
    imem[1]  = enc_r(0, 3'b111, 1, 1, 2); // and is not supported
    imem[64] = enc_addi(3, 1, 1);
    imem[65] = enc_jal(0, 0);
    run_test("illegal_opcode", 5, -1);

    errors += u_datapath.u_datapath_properties.fail_count;
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
len5_pkg.sv
branch_predictor.sv
fetch_stage.sv
backend.sv
datapath.sv
datapath_properties.sv
tb_datapath.sv

//--- Makefile
TOP = tb_datapath

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
